// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the MDEC testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module mdecTb --Mdir "$buildDir" -o mdecSim -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/mdecSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "All checks passed" "$logFile"; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1

// ==== source/mdecCommandSequencer.sv ====
`timescale 1ns/1ps

module mdecCommandSequencer (
	input  logic               i_clk,
	input  logic               i_resetChip,
	input  logic [31:0]        i_fifoData,
	input  logic               i_fifoEmpty,
	input  logic               i_halfReady,   // Stream port idle
	output logic               o_fifoPop,
	output logic               o_tableWrite,
	output mdecPkg::tableSel_t o_tableSel,
	output logic [4:0]         o_tableAddr,
	output logic [27:0]        o_tableData,
	output logic               o_halfWrite,
	output logic [15:0]        o_halfData,
	output logic               o_busy,
	output logic [15:0]        o_remaining,   // Words left minus 1
	output logic [1:0]         o_pixelFormat,
	output logic               o_pixelSigned,
	output logic               o_pixelSetBit15
);
	import mdecPkg::*;

	seqState_t   state;
	seqState_t   nextState;
	logic [16:0] remainHalf;     // Parameter halfwords still expected
	logic [16:0] remainMinusOne;
	logic [1:0]  decAmount;      // 1 per stream half, 2 per table word
	logic [4:0]  addrCount;      // Entry index within current table
	logic [2:0]  cmdType;
	logic        hasWord;
	logic        streamGo;
	logic        lastWord;
	logic        lastHalf;
	logic        lumaDone;
	logic        newCommand;

	assign cmdType    = i_fifoData[31:29];
	assign hasWord    = !i_fifoEmpty;
	assign streamGo   = hasWord && i_halfReady; // Handshake is the back-pressure
	assign lastWord   = (remainHalf == 17'd2);
	assign lastHalf   = (remainHalf == 17'd1);
	assign lumaDone   = (state == loadLuma) && (addrCount == 5'(quantWordsPerTable - 1));
	assign newCommand = (state == waitCommand) && hasWord;

	// ------------------------------
	// Next state and strobes
	// ------------------------------
	always_comb begin
		nextState    = state;
		o_fifoPop    = 1'b0;
		o_tableWrite = 1'b0;
		o_tableSel   = tableCos;
		o_halfWrite  = 1'b0;
		o_halfData   = i_fifoData[15:0]; // Low half goes first
		decAmount    = 2'd0;
		// Quant packing, bits 14..8 and 6..0 of each half
		o_tableData  = {i_fifoData[30:24], i_fifoData[22:16], i_fifoData[14:8], i_fifoData[6:0]};
		case (state)
		waitCommand: begin
			o_fifoPop = hasWord; // Unknown commands are simply dropped
			if (hasWord) begin
				case (cmdType)
				cmdStream:   nextState = (i_fifoData[15:0] != 16'd0) ? loadStreamLow : waitCommand;
				cmdQuant:    nextState = loadLuma;
				cmdCosTable: nextState = loadCos;
				default:     nextState = waitCommand;
				endcase
			end
		end
		loadStreamLow: begin
			o_halfWrite = streamGo;
			decAmount   = {1'b0, streamGo};
			if (streamGo) begin
				nextState = loadStreamHigh;
			end
		end
		loadStreamHigh: begin
			o_halfWrite = streamGo;
			o_halfData  = i_fifoData[31:16];
			o_fifoPop   = streamGo; // Word done after its high half
			decAmount   = {1'b0, streamGo};
			if (streamGo) begin
				nextState = lastHalf ? waitCommand : loadStreamLow;
			end
		end
		loadCos: begin
			o_fifoPop    = hasWord;
			o_tableWrite = hasWord;
			// Top 14 bits of each half, table store trims to 13
			o_tableData  = {i_fifoData[31:18], i_fifoData[15:2]};
			decAmount    = {hasWord, 1'b0};
			if (hasWord && lastWord) begin
				nextState = waitCommand;
			end
		end
		loadLuma, loadChroma: begin
			o_fifoPop    = hasWord;
			o_tableWrite = hasWord;
			o_tableSel   = (state == loadLuma) ? tableLuma : tableChroma;
			decAmount    = {hasWord, 1'b0};
			if (hasWord && lastWord) begin
				nextState = waitCommand; // Luma-only ends here too
			end else if (hasWord && lumaDone) begin
				nextState = loadChroma;
			end
		end
		default: nextState = waitCommand;
		endcase
	end

	// ------------------------------
	// State, counter, format fields
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			state           <= waitCommand;
			remainHalf      <= 17'd0;
			addrCount       <= 5'd0;
			o_pixelFormat   <= 2'd0;
			o_pixelSigned   <= 1'b0;
			o_pixelSetBit15 <= 1'b0;
		end else begin
			state <= nextState;
			if (newCommand) begin
				o_pixelFormat   <= i_fifoData[28:27]; // Any command word
				o_pixelSigned   <= i_fifoData[26];
				o_pixelSetBit15 <= i_fifoData[25];
				addrCount       <= 5'd0;
				case (cmdType)
				cmdStream:   remainHalf <= {i_fifoData[15:0], 1'b0}; // Words to halves
				cmdQuant:    remainHalf <= i_fifoData[0] ? 17'(4 * quantWordsPerTable)
					: 17'(2 * quantWordsPerTable);
				cmdCosTable: remainHalf <= 17'(2 * cosEntries);
				default:     remainHalf <= 17'd0;
				endcase
			end else begin
				remainHalf <= remainHalf - {15'd0, decAmount};
				if (o_tableWrite) begin
					addrCount <= lumaDone ? 5'd0 : addrCount + 5'd1; // Chroma restarts at 0
				end
			end
		end
	end

	assign remainMinusOne = remainHalf - 17'd1;
	assign o_remaining    = remainMinusOne[16:1]; // 0xFFFF when idle
	assign o_busy         = (state != waitCommand);
	assign o_tableAddr    = addrCount;

	// Counter must cover every halfword consumed by a load
	noUnderflow: assert property (@(posedge i_clk) disable iff (i_resetChip)
		(decAmount != 2'd0) |-> (remainHalf >= {15'd0, decAmount}))
		else $error("Parameter counter underflow");

endmodule

// ==== source/mdecInputFifo.sv ====
`timescale 1ns/1ps

module mdecInputFifo (
	input  logic        i_clk,
	input  logic        i_resetChip,
	input  logic        i_push,
	input  logic [31:0] i_pushData,
	input  logic        i_pop,
	output logic [31:0] o_headData, // Head word, valid while not empty
	output logic        o_empty,
	output logic        o_full
);
	import mdecPkg::*;

	logic [31:0]             fifoMem [1 << fifoDepthLog];
	logic [fifoDepthLog-1:0] wrPtr;
	logic [fifoDepthLog-1:0] rdPtr;
	logic [fifoDepthLog:0]   level; // One extra bit to hold a full count
	logic                    doPush;
	logic                    doPop;

	assign doPush = i_push && !o_full; // Push on full is lost
	assign doPop  = i_pop && !o_empty;

	// Show-ahead read, no output register
	assign o_headData = fifoMem[rdPtr];
	assign o_empty    = (level == '0);
	assign o_full     = level[fifoDepthLog]; // MSB only set at full depth

	// Storage
	always_ff @(posedge i_clk) begin
		if (doPush) begin
			fifoMem[wrPtr] <= i_pushData;
		end
	end

	// ------------------------------
	// Pointers and level
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1; // Wraps at depth
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
			2'b10:   level <= level + 1'b1;
			2'b01:   level <= level - 1'b1;
			default: level <= level; // Both or neither
			endcase
		end
	end

	// Writer is expected to watch o_canWriteReg0 at the top
	pushWhenFull: assert property (@(posedge i_clk) disable iff (i_resetChip)
		!(i_push && o_full)) else $warning("Input FIFO written while full, word dropped");

	// Sequencer only pops a presented head word
	popWhenEmpty: assert property (@(posedge i_clk) disable iff (i_resetChip)
		!(i_pop && o_empty)) else $error("Input FIFO popped while empty");

endmodule

// ==== source/mdecPkg.sv ====
package mdecPkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int fifoDepthLog       = 5;  // 32-word input FIFO
	localparam int cosEntries         = 32; // One entry per parameter word
	localparam int quantWordsPerTable = 16; // Four 7-bit values per word
	localparam int cosWidth           = 26; // Two 13-bit halves
	localparam int quantWidth         = 28;

	// ------------------------------
	// Command codes
	// ------------------------------
	// Taken from bits 31..29 of a command word
	localparam logic [2:0] cmdStream   = 3'd1;
	localparam logic [2:0] cmdQuant    = 3'd2;
	localparam logic [2:0] cmdCosTable = 3'd3;

	// Sequencer states
	typedef enum logic [2:0] {
		waitCommand    = 3'd0,
		loadStreamLow  = 3'd1, // First halfword of a stream word
		loadStreamHigh = 3'd2,
		loadCos        = 3'd3,
		loadLuma       = 3'd4,
		loadChroma     = 3'd5  // Only after luma, when command bit 0 set
	} seqState_t;

	typedef enum logic [1:0] {
		tableCos    = 2'd0,
		tableLuma   = 2'd1,
		tableChroma = 2'd2
	} tableSel_t;

endpackage

// ==== source/mdecRegisters.sv ====
`timescale 1ns/1ps

module mdecRegisters (
	input  logic               i_clk,
	input  logic               i_resetChip,
	input  logic               i_regSelect,    // 0 selects +0 and 1 selects +4
	input  logic               i_write,
	input  logic               i_read,
	input  logic [31:0]        i_valueIn,
	input  logic               i_streamAck,
	input  mdecPkg::tableSel_t i_tableSelRd,
	input  logic [4:0]         i_tableAddrRd,
	output logic [31:0]        o_valueOut,
	output logic               o_canWriteReg0, // FIFO has room
	output logic               o_dmaWriteRequest,
	output logic               o_dmaReadRequest,
	output logic               o_streamReq,
	output logic [15:0]        o_streamData,
	output logic [27:0]        o_tableDataRd
);
	import mdecPkg::*;

	logic        writeReg0;
	logic        writeReg1;
	logic        softReset;     // Registered +4 bit 31
	logic        resetChip;     // Pin reset or soft reset
	logic        allowDma0;
	logic        allowDma1;
	logic        pRegSelect;
	logic        outFifoHasData; // No output FIFO in this block
	logic [31:0] fifoData;
	logic        fifoEmpty;
	logic        fifoFull;
	logic        fifoPop;
	logic        tableWrite;
	tableSel_t   tableSelWr;
	logic [4:0]  tableAddr;
	logic [27:0] tableData;
	logic        halfWrite;
	logic [15:0] halfData;
	logic        halfReady;
	logic        seqBusy;
	logic [15:0] remaining;
	logic [1:0]  pixelFormat;
	logic        pixelSigned;
	logic        pixelSetBit15;
	logic [31:0] statusWord;

	assign writeReg0      = i_write && !i_regSelect;
	assign writeReg1      = i_write && i_regSelect;
	assign resetChip      = i_resetChip || softReset;
	assign outFifoHasData = 1'b0;

	// ------------------------------
	// Control register
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			softReset <= 1'b0;
		end else begin
			softReset <= writeReg1 && i_valueIn[31]; // One-cycle pulse
		end
	end

	always_ff @(posedge i_clk) begin
		if (resetChip) begin
			allowDma0  <= 1'b1;
			allowDma1  <= 1'b1;
			pRegSelect <= 1'b0;
		end else begin
			pRegSelect <= i_regSelect; // Read data follows last cycle's select
			if (writeReg1) begin
				allowDma0 <= i_valueIn[30]; // Data-in request enable
				allowDma1 <= i_valueIn[29]; // Data-out request enable
			end
		end
	end

	mdecInputFifo u_fifo (
		.i_clk(i_clk), .i_resetChip(resetChip),
		.i_push(writeReg0), .i_pushData(i_valueIn), .i_pop(fifoPop),
		.o_headData(fifoData), .o_empty(fifoEmpty), .o_full(fifoFull)
	);

	mdecCommandSequencer u_seq (
		.i_clk(i_clk), .i_resetChip(resetChip),
		.i_fifoData(fifoData), .i_fifoEmpty(fifoEmpty), .i_halfReady(halfReady),
		.o_fifoPop(fifoPop), .o_tableWrite(tableWrite), .o_tableSel(tableSelWr),
		.o_tableAddr(tableAddr), .o_tableData(tableData),
		.o_halfWrite(halfWrite), .o_halfData(halfData),
		.o_busy(seqBusy), .o_remaining(remaining), .o_pixelFormat(pixelFormat),
		.o_pixelSigned(pixelSigned), .o_pixelSetBit15(pixelSetBit15)
	);

	mdecTableStore u_tables (
		.i_clk(i_clk), .i_write(tableWrite), .i_selWr(tableSelWr),
		.i_addrWr(tableAddr), .i_dataWr(tableData),
		.i_selRd(i_tableSelRd), .i_addrRd(i_tableAddrRd), .o_dataRd(o_tableDataRd)
	);

	mdecStreamPort u_stream (
		.i_clk(i_clk), .i_resetChip(resetChip),
		.i_halfWrite(halfWrite), .i_halfData(halfData), .i_streamAck(i_streamAck),
		.o_halfReady(halfReady), .o_streamReq(o_streamReq), .o_streamData(o_streamData)
	);

	// ------------------------------
	// Status word
	// ------------------------------
	assign statusWord[31]    = !outFifoHasData;                      // Output empty
	assign statusWord[30]    = fifoFull;
	assign statusWord[29]    = seqBusy || !fifoEmpty || !halfReady;  // Busy
	assign statusWord[28]    = !fifoFull && allowDma0;
	assign statusWord[27]    = outFifoHasData && allowDma1;
	assign statusWord[26:25] = pixelFormat;
	assign statusWord[24]    = pixelSigned;
	assign statusWord[23]    = pixelSetBit15;
	assign statusWord[22:16] = 7'd0; // Current block always zero
	assign statusWord[15:0]  = remaining;

	assign o_valueOut        = pRegSelect ? statusWord : 32'd0; // +0 reads zero
	assign o_canWriteReg0    = !fifoFull;
	assign o_dmaWriteRequest = statusWord[28];
	assign o_dmaReadRequest  = statusWord[27];

	// Bus side never reads and writes together
	busExclusive: assert property (@(posedge i_clk) disable iff (i_resetChip)
		!(i_read && i_write)) else $error("Read and write in same cycle");

endmodule

// ==== source/mdecStreamPort.sv ====
`timescale 1ns/1ps

module mdecStreamPort (
	input  logic        i_clk,
	input  logic        i_resetChip,
	input  logic        i_halfWrite,
	input  logic [15:0] i_halfData,
	input  logic        i_streamAck,  // From decoder core
	output logic        o_halfReady,
	output logic        o_streamReq,
	output logic [15:0] o_streamData
);
	// Four-phase handshake states
	typedef enum logic [1:0] {
		portIdle       = 2'd0,
		portRequest    = 2'd1, // Req high while waiting for ack
		portWaitAckLow = 2'd2  // Req dropped until ack released
	} portState_t;

	portState_t  portState;
	logic [15:0] dataReg;

	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			portState <= portIdle;
		end else begin
			case (portState)
			portIdle:       portState <= i_halfWrite ? portRequest : portIdle;
			portRequest:    portState <= i_streamAck ? portWaitAckLow : portRequest;
			portWaitAckLow: portState <= i_streamAck ? portWaitAckLow : portIdle;
			default:        portState <= portIdle;
			endcase
		end
	end

	// Halfword held for the whole transfer
	always_ff @(posedge i_clk) begin
		if (i_halfWrite) begin
			dataReg <= i_halfData;
		end
	end

	assign o_halfReady  = (portState == portIdle);
	assign o_streamReq  = (portState == portRequest); // Cycle after accept
	assign o_streamData = dataReg;

	// Core may sample data at any cycle of req
	dataStable: assert property (@(posedge i_clk) disable iff (i_resetChip)
		o_streamReq |=> (!o_streamReq || $stable(o_streamData)))
		else $error("Stream data changed during request");

endmodule

// ==== source/mdecTableStore.sv ====
`timescale 1ns/1ps

module mdecTableStore (
	input  logic               i_clk,
	input  logic               i_write,
	input  mdecPkg::tableSel_t i_selWr,
	input  logic [4:0]         i_addrWr,
	input  logic [27:0]        i_dataWr,
	input  mdecPkg::tableSel_t i_selRd,
	input  logic [4:0]         i_addrRd,
	output logic [27:0]        o_dataRd
);
	import mdecPkg::*;

	logic [cosWidth-1:0]   cosTable    [cosEntries];
	logic [quantWidth-1:0] lumaTable   [quantWordsPerTable];
	logic [quantWidth-1:0] chromaTable [quantWordsPerTable];
	logic [cosWidth-1:0]   cosEntry;

	// Cos word arrives as two 14-bit halves, keep top 13 of each
	assign cosEntry = {i_dataWr[27:15], i_dataWr[13:1]};

	// ------------------------------
	// Write port
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_write) begin
			case (i_selWr)
			tableCos:    cosTable[i_addrWr]         <= cosEntry;
			tableLuma:   lumaTable[i_addrWr[3:0]]   <= i_dataWr; // 16 entries
			tableChroma: chromaTable[i_addrWr[3:0]] <= i_dataWr;
			default: begin
				// No fourth table
			end
			endcase
		end
	end

	// ------------------------------
	// Read port, combinational
	// ------------------------------
	always_comb begin
		case (i_selRd)
		tableCos:    o_dataRd = {{(quantWidth - cosWidth){1'b0}}, cosTable[i_addrRd]};
		tableLuma:   o_dataRd = lumaTable[i_addrRd[3:0]];
		tableChroma: o_dataRd = chromaTable[i_addrRd[3:0]];
		default:     o_dataRd = '0;
		endcase
	end

endmodule

// ==== sources.f ====
source/mdecPkg.sv
source/mdecInputFifo.sv
source/mdecCommandSequencer.sv
source/mdecTableStore.sv
source/mdecStreamPort.sv
source/mdecRegisters.sv
verif/tbClock.sv
verif/mdecTb.sv

// ==== verif/mdecTb.sv ====
`timescale 1ns/1ps

module mdecTb;
	import mdecPkg::*;

	localparam int          timeoutCycles = 2000;
	localparam logic [31:0] lfsrSeed      = 32'd90171;

	logic        clk;
	logic        resetChip;
	logic        regSelect;
	logic        busWrite;
	logic        busRead;
	logic [31:0] valueIn;
	logic        streamAck;
	tableSel_t   tableSelRd;
	logic [4:0]  tableAddrRd;
	logic [31:0] valueOut;
	logic        canWriteReg0;
	logic        dmaWriteRequest;
	logic        dmaReadRequest;
	logic        streamReq;
	logic [15:0] streamData;
	logic [27:0] tableDataRd;

	int          mismatchCount;
	int          failCount;
	logic [31:0] stimState;   // Stimulus LFSR
	logic [31:0] ackState;    // Core responder LFSR
	logic        ackEnable;   // Core answers requests when set

	// ------------------------------
	// Reference model
	// ------------------------------
	logic [cosWidth-1:0]   cosModel    [cosEntries];
	logic [quantWidth-1:0] lumaModel   [quantWordsPerTable];
	logic [quantWidth-1:0] chromaModel [quantWordsPerTable];
	logic [3:0]            fmtModel;    // Command bits 28..25
	logic [15:0]           expHalves [$];
	logic [15:0]           gotHalves [$]; // Filled by the core responder

	tbClock u_clock (
		.o_clk(clk),
		.o_resetChip(resetChip)
	);

	mdecRegisters u_dut (
		.i_clk(clk), .i_resetChip(resetChip),
		.i_regSelect(regSelect), .i_write(busWrite), .i_read(busRead),
		.i_valueIn(valueIn), .i_streamAck(streamAck),
		.i_tableSelRd(tableSelRd), .i_tableAddrRd(tableAddrRd),
		.o_valueOut(valueOut), .o_canWriteReg0(canWriteReg0),
		.o_dmaWriteRequest(dmaWriteRequest), .o_dmaReadRequest(dmaReadRequest),
		.o_streamReq(streamReq), .o_streamData(streamData), .o_tableDataRd(tableDataRd)
	);

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic takeBits(input int nBits, inout logic [31:0] state,
		output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nBits; i++) begin
			state = lfsrStep(state);
			value = {value[30:0], state[0]};
		end
	endtask

	// Bits 14..8 and 6..0 of each half, high half first
	function automatic logic [27:0] packQuant(input logic [31:0] word);
		return {word[30:24], word[22:16], word[14:8], word[6:0]};
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		mismatchCount++;
		$display("Mismatch %s: expected %h actual %h", name, expected, actual);
	endtask

	task automatic reportFailure(input string what);
		failCount++;
		$display("Error: %s", what);
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1; // Drive point
	endtask

	// ------------------------------
	// Bus access
	// ------------------------------
	task automatic writeReg(input logic sel, input logic [31:0] value);
		regSelect = sel;
		valueIn   = value;
		busWrite  = 1'b1;
		nextCycle();
		busWrite  = 1'b0;
	endtask

	task automatic writeFifo(input logic [31:0] value);
		int          cycles;
		logic [31:0] gap;
		cycles = 0;
		while (!canWriteReg0 && cycles < timeoutCycles) begin
			nextCycle();
			cycles++;
		end
		if (!canWriteReg0) begin
			reportFailure("input FIFO stayed full, word not written");
		end else begin
			writeReg(1'b0, value);
		end
		takeBits(2, stimState, gap); // 0 to 3 idle cycles
		repeat (gap) nextCycle();
	endtask

	// Read data follows the select of the previous cycle
	task automatic readStatus(output logic [31:0] status);
		regSelect = 1'b1;
		busRead   = 1'b1;
		nextCycle();
		status  = valueOut;
		busRead = 1'b0;
	endtask

	// Polls busy, remaining field must only count down
	task automatic waitIdle(input string name, input int remStart, output logic [31:0] status);
		int cycles;
		int prevRem;
		int curRem;
		cycles  = 0;
		prevRem = remStart;
		readStatus(status);
		while (status[29] && cycles < timeoutCycles) begin
			curRem = (status[15:0] == 16'hFFFF) ? -1 : int'(status[15:0]); // Done reads as -1
			if (curRem > prevRem) begin
				reportMismatch($sformatf("%s remaining", name), 32'(prevRem), 32'(curRem));
			end
			prevRem = curRem;
			readStatus(status);
			cycles++;
		end
		if (status[29]) begin
			reportFailure($sformatf("%s: busy never cleared", name));
		end
		if (status[15:0] !== 16'hFFFF) begin
			reportMismatch($sformatf("%s remaining at idle", name), 32'hFFFF, 32'(status[15:0]));
		end
		if (status[26:23] !== fmtModel) begin
			reportMismatch($sformatf("%s format", name), 32'(fmtModel), 32'(status[26:23]));
		end
	endtask

	task automatic checkResetState(input string name);
		logic [31:0] status;
		readStatus(status);
		if (status !== 32'h9000FFFF) begin
			reportMismatch($sformatf("%s status", name), 32'h9000FFFF, status);
		end
		if (streamReq !== 1'b0) begin
			reportMismatch($sformatf("%s stream request", name), 32'd0, 32'(streamReq));
		end
		if (canWriteReg0 !== 1'b1) begin
			reportMismatch($sformatf("%s can write", name), 32'd1, 32'(canWriteReg0));
		end
	endtask

	// Random command bits, opcode on top
	task automatic makeCommand(input logic [2:0] code, output logic [31:0] cmd);
		logic [31:0] bits;
		takeBits(29, stimState, bits);
		cmd      = {code, bits[28:0]};
		fmtModel = cmd[28:25]; // Latched by any command
	endtask

	task automatic checkTable(input string name, input tableSel_t sel, input int entries);
		logic [27:0] expected;
		for (int i = 0; i < entries; i++) begin
			tableSelRd  = sel;
			tableAddrRd = 5'(i);
			nextCycle();
			case (sel)
			tableCos:  expected = {2'b00, cosModel[5'(i)]};
			tableLuma: expected = lumaModel[4'(i)];
			default:   expected = chromaModel[4'(i)];
			endcase
			if (tableDataRd !== expected) begin
				reportMismatch($sformatf("%s entry %0d", name, i), 32'(expected), 32'(tableDataRd));
			end
		end
	endtask

	// ------------------------------
	// Command scenarios
	// ------------------------------
	task automatic runCosLoad();
		logic [31:0] cmd;
		logic [31:0] word;
		logic [31:0] status;
		makeCommand(cmdCosTable, cmd);
		writeFifo(cmd);
		for (int i = 0; i < cosEntries; i++) begin
			takeBits(32, stimState, word);
			cosModel[5'(i)] = {word[31:19], word[15:3]}; // Top 13 of each half
			writeFifo(word);
		end
		waitIdle("cosine load", cosEntries - 1, status);
		checkTable("cosine load", tableCos, cosEntries);
	endtask

	task automatic runQuantLoad(input logic withChroma);
		logic [31:0] cmd;
		logic [31:0] word;
		logic [31:0] status;
		int          words;
		string       name;
		name  = withChroma ? "luma and chroma load" : "luma load";
		words = withChroma ? 2 * quantWordsPerTable : quantWordsPerTable;
		makeCommand(cmdQuant, cmd);
		cmd[0] = withChroma;
		writeFifo(cmd);
		for (int i = 0; i < words; i++) begin
			takeBits(32, stimState, word);
			if (i < quantWordsPerTable) begin
				lumaModel[4'(i)] = packQuant(word);
			end else begin
				chromaModel[4'(i - quantWordsPerTable)] = packQuant(word);
			end
			writeFifo(word);
		end
		waitIdle(name, words - 1, status);
		checkTable(name, tableLuma, quantWordsPerTable);
		checkTable(name, tableChroma, quantWordsPerTable); // Untouched by luma-only
		checkTable(name, tableCos, cosEntries);
	endtask

	task automatic runStream(input int words);
		logic [31:0] cmd;
		logic [31:0] word;
		logic [31:0] status;
		makeCommand(cmdStream, cmd);
		cmd[15:0] = 16'(words);
		expHalves.delete();
		gotHalves.delete();
		writeFifo(cmd);
		for (int i = 0; i < words; i++) begin
			takeBits(32, stimState, word);
			expHalves.push_back(word[15:0]);  // Low half first
			expHalves.push_back(word[31:16]);
			writeFifo(word);
		end
		waitIdle("stream", words - 1, status);
		if (gotHalves.size() != expHalves.size()) begin
			reportMismatch("stream halfword count", 32'(expHalves.size()), 32'(gotHalves.size()));
		end else begin
			for (int i = 0; i < expHalves.size(); i++) begin
				if (gotHalves[i] !== expHalves[i]) begin
					reportMismatch($sformatf("stream halfword %0d", i),
						32'(expHalves[i]), 32'(gotHalves[i]));
				end
			end
		end
	endtask

	// ------------------------------
	// Core side of the req/ack port
	// ------------------------------
	initial begin : ackResponder
		logic [31:0] delay;
		int          cycles;
		streamAck = 1'b0;
		ackState  = lfsrSeed;
		forever begin
			nextCycle();
			if (ackEnable && streamReq) begin
				gotHalves.push_back(streamData);
				takeBits(2, ackState, delay); // 0 to 3 cycles
				repeat (delay) nextCycle();
				streamAck = 1'b1;
				nextCycle();
				if (streamReq !== 1'b0) begin
					reportMismatch("request drop after ack", 32'd0, 32'(streamReq));
				end
				cycles = 0;
				while (streamReq && cycles < timeoutCycles) begin
					nextCycle();
					cycles++;
				end
				if (streamReq) begin
					reportFailure("stream request never dropped after ack");
				end
				streamAck = 1'b0; // Port returns to idle after this
			end
		end
	end

	initial begin : mainSequence
		logic [31:0] status;
		logic [31:0] cmd;
		logic [31:0] word;
		int          cycles;
		regSelect     = 1'b0;
		busWrite      = 1'b0;
		busRead       = 1'b0;
		valueIn       = '0;
		tableSelRd    = tableCos;
		tableAddrRd   = '0;
		ackEnable     = 1'b1;
		mismatchCount = 0;
		failCount     = 0;
		fmtModel      = '0;
		stimState     = lfsrSeed;

		// Reset is sampled at the edge, before it moves
		cycles = 0;
		@(posedge clk);
		while (resetChip && cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		#1;
		if (resetChip) begin
			reportFailure("reset was never released");
		end

		checkResetState("reset");
		runCosLoad();
		runQuantLoad(1'b1);
		runQuantLoad(1'b0);
		repeat (3) begin
			takeBits(3, stimState, word);
			runStream(int'(word) + 1); // 1 to 8 words
		end

		// Full FIFO, core never acks so the stream stalls
		ackEnable = 1'b0;
		nextCycle();
		makeCommand(cmdStream, cmd);
		cmd[15:0] = 16'd33;
		writeReg(1'b0, cmd);
		for (int i = 0; i < 33; i++) begin
			takeBits(32, stimState, word);
			writeReg(1'b0, word); // Last one lands on a full FIFO
		end
		readStatus(status);
		if (status[30] !== 1'b1) begin
			reportMismatch("full FIFO status bit 30", 32'd1, 32'(status[30]));
		end
		if (canWriteReg0 !== 1'b0) begin
			reportMismatch("full FIFO can write", 32'd0, 32'(canWriteReg0));
		end
		if (dmaWriteRequest !== 1'b0) begin
			reportMismatch("full FIFO DMA write request", 32'd0, 32'(dmaWriteRequest));
		end

		// Soft reset from the full state
		writeReg(1'b1, 32'h80000000);
		nextCycle(); // Registered reset pulse
		checkResetState("soft reset");
		if (dmaWriteRequest !== 1'b1) begin
			reportMismatch("soft reset DMA write request", 32'd1, 32'(dmaWriteRequest));
		end

		// Both DMA enables off
		writeReg(1'b1, 32'h00000000);
		readStatus(status);
		if (status[28] !== 1'b0) begin
			reportMismatch("DMA disable status bit 28", 32'd0, 32'(status[28]));
		end
		if (dmaWriteRequest !== 1'b0) begin
			reportMismatch("DMA disable write request", 32'd0, 32'(dmaWriteRequest));
		end
		if (dmaReadRequest !== 1'b0) begin
			reportMismatch("DMA disable read request", 32'd0, 32'(dmaReadRequest));
		end

		$display("Summary: %0d mismatches, %0d other errors", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	output logic o_clk,
	output logic o_resetChip
);
	// 10 ns period
	initial begin
		o_clk = 1'b0;
		forever begin
			#5 o_clk = ~o_clk;
		end
	end

	// Held for 4 rising edges, released just after the last one
	initial begin
		o_resetChip = 1'b1;
		repeat (4) @(posedge o_clk);
		#1 o_resetChip = 1'b0;
	end

endmodule
